//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0]         word_t;      // register or pc value
    typedef logic [31:0]             inst_t;      // raw instruction
    typedef logic [4:0]              reg_addr_t;
    typedef logic [$clog2(XLEN)-1:0] shamt_t;     // 6-bit shift amount

    // decoded operation, nop sits at zero so an idle decoder gives a bubble op
    typedef enum logic [5:0] {
        NOP = 6'd0,
        // register-register
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        // register-immediate
        ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU,
        // 32-bit word forms
        ADDW, SUBW, ADDIW,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LD,
        SD,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,   // immediate csr forms take the zimm from the rs1 field
        CSRRSI,
        CSRRCI,
        ECALL,
        MRET
    } op_t;

endpackage

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_ADDR_WIDTH = 12;

    // machine-mode csr index, taken from inst[31:20]
    typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;

    // read-modify-write flavour of a csr instruction
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,   // not a csr op
        CSR_WRITE = 2'd1,   // csrrw, csrrwi
        CSR_SET   = 2'd2,   // csrrs, csrrsi
        CSR_CLEAR = 2'd3    // csrrc, csrrci
    } csr_op_t;

endpackage

`default_nettype wire

//--- logic/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  isa_pkg::reg_addr_t rs1_addr,
    input  isa_pkg::reg_addr_t rs2_addr,
    input  isa_pkg::word_t     rs1_value,
    input  isa_pkg::word_t     rs2_value,
    input  logic               fwd1_write_enable,
    input  isa_pkg::reg_addr_t fwd1_dest,
    input  isa_pkg::word_t     fwd1_data,
    input  logic               fwd2_write_enable,
    input  isa_pkg::reg_addr_t fwd2_dest,
    input  isa_pkg::word_t     fwd2_data,
    output isa_pkg::word_t     op1,
    output isa_pkg::word_t     op2
);

    // x0 is hardwired and a write to it never bypasses
    function automatic logic fwd_hit(
        input logic               write_enable,
        input isa_pkg::reg_addr_t dest,
        input isa_pkg::reg_addr_t src
    );
        return write_enable && (dest != '0) && (dest == src);
    endfunction

    function automatic isa_pkg::word_t pick(
        input isa_pkg::reg_addr_t src,
        input isa_pkg::word_t     reg_value
    );
        if (fwd_hit(fwd1_write_enable, fwd1_dest, src)) begin
            return fwd1_data;   // newest result wins
        end else if (fwd_hit(fwd2_write_enable, fwd2_dest, src)) begin
            return fwd2_data;
        end
        return reg_value;
    endfunction

    always_comb begin
        op1 = pick(rs1_addr, rs1_value);
        op2 = pick(rs2_addr, rs2_value);
    end

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  isa_pkg::op_t       op,
    input  csr_pkg::csr_op_t   csr_op,
    input  isa_pkg::word_t     op1,
    input  isa_pkg::word_t     op2,
    input  isa_pkg::reg_addr_t rs1_addr,
    input  isa_pkg::word_t     immed,
    input  isa_pkg::word_t     pc,
    input  isa_pkg::word_t     csr_value,
    output isa_pkg::word_t     result,
    output isa_pkg::word_t     csr_new
);

    isa_pkg::shamt_t shamt_r;     // register shifts
    isa_pkg::shamt_t shamt_i;     // immediate shifts
    logic [31:0]     word_sum;    // low half of the w ops
    isa_pkg::word_t  csr_src;
    logic            csr_immed;

    function automatic isa_pkg::word_t sext_word(input logic [31:0] w);
        return {{(isa_pkg::XLEN-32){w[31]}}, w};
    endfunction

    assign shamt_r = op2[$bits(isa_pkg::shamt_t)-1:0];
    assign shamt_i = immed[$bits(isa_pkg::shamt_t)-1:0];

    always_comb begin
        case (op)
            isa_pkg::SUBW:  word_sum = op1[31:0] - op2[31:0];
            isa_pkg::ADDIW: word_sum = op1[31:0] + immed[31:0];
            default:        word_sum = op1[31:0] + op2[31:0];
        endcase
    end

    always_comb begin
        case (op)
            isa_pkg::ADD:   result = op1 + op2;
            isa_pkg::SUB:   result = op1 - op2;
            isa_pkg::AND:   result = op1 & op2;
            isa_pkg::OR:    result = op1 | op2;
            isa_pkg::XOR:   result = op1 ^ op2;
            isa_pkg::SLL:   result = op1 << shamt_r;
            isa_pkg::SRL:   result = op1 >> shamt_r;
            isa_pkg::SRA:   result = $signed(op1) >>> shamt_r;
            isa_pkg::SLT:   result = isa_pkg::word_t'($signed(op1) < $signed(op2));
            isa_pkg::SLTU:  result = isa_pkg::word_t'(op1 < op2);

            isa_pkg::ADDI:  result = op1 + immed;
            isa_pkg::ANDI:  result = op1 & immed;
            isa_pkg::ORI:   result = op1 | immed;
            isa_pkg::XORI:  result = op1 ^ immed;
            isa_pkg::SLLI:  result = op1 << shamt_i;
            isa_pkg::SRLI:  result = op1 >> shamt_i;
            isa_pkg::SRAI:  result = $signed(op1) >>> shamt_i;
            isa_pkg::SLTI:  result = isa_pkg::word_t'($signed(op1) < $signed(immed));
            isa_pkg::SLTIU: result = isa_pkg::word_t'(op1 < immed);

            isa_pkg::ADDW,
            isa_pkg::SUBW,
            isa_pkg::ADDIW: result = sext_word(word_sum);

            isa_pkg::LUI:   result = immed;           // decoder already shifted it
            isa_pkg::AUIPC: result = pc + immed;

            isa_pkg::JAL,
            isa_pkg::JALR:  result = pc + isa_pkg::word_t'(4);   // link address

            isa_pkg::LD,
            isa_pkg::SD:    result = op1 + immed;     // effective address

            isa_pkg::CSRRW,
            isa_pkg::CSRRS,
            isa_pkg::CSRRC,
            isa_pkg::CSRRWI,
            isa_pkg::CSRRSI,
            isa_pkg::CSRRCI: result = csr_value;     // rd gets the old csr

            default:        result = '0;
        endcase
    end

    assign csr_immed = op inside {isa_pkg::CSRRWI, isa_pkg::CSRRSI, isa_pkg::CSRRCI};

    // zimm is the rs1 field, zero extended
    assign csr_src = csr_immed ? isa_pkg::word_t'(rs1_addr) : op1;

    always_comb begin
        case (csr_op)
            csr_pkg::CSR_WRITE: csr_new = csr_src;
            csr_pkg::CSR_SET:   csr_new = csr_value | csr_src;
            csr_pkg::CSR_CLEAR: csr_new = csr_value & ~csr_src;
            default:            csr_new = csr_value;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  isa_pkg::op_t   op,
    input  isa_pkg::word_t op1,
    input  isa_pkg::word_t op2,
    input  isa_pkg::word_t pc,
    input  isa_pkg::word_t immed,
    input  isa_pkg::word_t mtvec,
    input  isa_pkg::word_t mepc,
    output logic           taken,
    output isa_pkg::word_t target
);

    isa_pkg::word_t pc_rel;
    isa_pkg::word_t jalr_sum;

    assign pc_rel   = pc + immed;
    assign jalr_sum = op1 + immed;

    always_comb begin
        taken  = 1'b0;
        target = pc_rel;
        case (op)
            isa_pkg::BEQ:  taken = (op1 == op2);
            isa_pkg::BNE:  taken = (op1 != op2);
            isa_pkg::BLT:  taken = ($signed(op1) < $signed(op2));
            isa_pkg::BGE:  taken = ($signed(op1) >= $signed(op2));
            isa_pkg::BLTU: taken = (op1 < op2);
            isa_pkg::BGEU: taken = (op1 >= op2);
            isa_pkg::JAL: begin
                taken = 1'b1;
            end
            isa_pkg::JALR: begin
                taken  = 1'b1;
                target = {jalr_sum[isa_pkg::XLEN-1:1], 1'b0};
            end
            isa_pkg::ECALL: begin
                taken  = 1'b1;
                target = {mtvec[isa_pkg::XLEN-1:2], 2'b00};   // direct mode, drop MODE bits
            end
            isa_pkg::MRET: begin
                taken  = 1'b1;
                target = {mepc[isa_pkg::XLEN-1:1], 1'b0};
            end
            default: ;
        endcase
    end

    // relies on decode handing in even branch offsets and an aligned pc
    always_comb begin
        if (taken) begin
            assert (target[0] == 1'b0)
                else $error("taken target is odd");
        end
    end

endmodule

`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic               clk,
    input  logic               reset,

    input  logic               in_valid,
    input  isa_pkg::op_t       op,
    input  isa_pkg::inst_t     inst,
    input  isa_pkg::word_t     pc,
    input  isa_pkg::reg_addr_t rs1_addr,
    input  isa_pkg::reg_addr_t rs2_addr,
    input  isa_pkg::word_t     rs1_value,
    input  isa_pkg::word_t     rs2_value,
    input  isa_pkg::word_t     immed,
    input  isa_pkg::word_t     csr_value,
    input  isa_pkg::word_t     mtvec,
    input  isa_pkg::word_t     mepc,

    input  logic               fwd1_write_enable,   // from memory stage
    input  isa_pkg::reg_addr_t fwd1_dest,
    input  isa_pkg::word_t     fwd1_data,
    input  logic               fwd2_write_enable,   // from writeback
    input  isa_pkg::reg_addr_t fwd2_dest,
    input  isa_pkg::word_t     fwd2_data,

    output logic               fwd_write_enable,
    output isa_pkg::reg_addr_t fwd_dest,
    output isa_pkg::word_t     fwd_data,

    output logic               out_valid,
    output isa_pkg::op_t       out_op,
    output isa_pkg::word_t     out_pc,
    output isa_pkg::word_t     alu_result,
    output isa_pkg::word_t     store_data,
    output logic               jump_taken,
    output isa_pkg::word_t     jump_target,
    output logic               csr_write_enable,
    output csr_pkg::csr_addr_t csr_addr,
    output isa_pkg::word_t     csr_write_data,
    output logic               ecall,
    output logic               mret
);

    isa_pkg::word_t   op1;
    isa_pkg::word_t   op2;
    isa_pkg::word_t   alu_out;
    isa_pkg::word_t   csr_new;
    logic             taken;
    isa_pkg::word_t   target;
    csr_pkg::csr_op_t csr_op;
    logic             writes_rd;

    always_comb begin
        case (op)
            isa_pkg::CSRRW, isa_pkg::CSRRWI: csr_op = csr_pkg::CSR_WRITE;
            isa_pkg::CSRRS, isa_pkg::CSRRSI: csr_op = csr_pkg::CSR_SET;
            isa_pkg::CSRRC, isa_pkg::CSRRCI: csr_op = csr_pkg::CSR_CLEAR;
            default:                         csr_op = csr_pkg::CSR_NONE;
        endcase
    end

    // branches, stores, ecall, mret and nop leave rd alone
    assign writes_rd = !(op inside {isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT,
                                    isa_pkg::BGE, isa_pkg::BLTU, isa_pkg::BGEU,
                                    isa_pkg::SD, isa_pkg::ECALL, isa_pkg::MRET,
                                    isa_pkg::NOP});

    operand_forward i_operand_forward (
        .rs1_addr          (rs1_addr),
        .rs2_addr          (rs2_addr),
        .rs1_value         (rs1_value),
        .rs2_value         (rs2_value),
        .fwd1_write_enable (fwd1_write_enable),
        .fwd1_dest         (fwd1_dest),
        .fwd1_data         (fwd1_data),
        .fwd2_write_enable (fwd2_write_enable),
        .fwd2_dest         (fwd2_dest),
        .fwd2_data         (fwd2_data),
        .op1               (op1),
        .op2               (op2)
    );

    alu i_alu (
        .op        (op),
        .csr_op    (csr_op),
        .op1       (op1),
        .op2       (op2),
        .rs1_addr  (rs1_addr),
        .immed     (immed),
        .pc        (pc),
        .csr_value (csr_value),
        .result    (alu_out),
        .csr_new   (csr_new)
    );

    branch_unit i_branch_unit (
        .op     (op),
        .op1    (op1),
        .op2    (op2),
        .pc     (pc),
        .immed  (immed),
        .mtvec  (mtvec),
        .mepc   (mepc),
        .taken  (taken),
        .target (target)
    );

    // same-cycle bypass towards decode
    assign fwd_write_enable = in_valid && writes_rd;
    assign fwd_dest         = inst[11:7];
    assign fwd_data         = alu_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid        <= 1'b0;
            jump_taken       <= 1'b0;
            csr_write_enable <= 1'b0;
            ecall            <= 1'b0;
            mret             <= 1'b0;
        end else begin
            out_valid        <= in_valid;
            jump_taken       <= in_valid && taken;
            csr_write_enable <= in_valid && (csr_op != csr_pkg::CSR_NONE);
            ecall            <= in_valid && (op == isa_pkg::ECALL);
            mret             <= in_valid && (op == isa_pkg::MRET);
        end
    end

    always_ff @(posedge clk) begin
        out_op         <= op;
        out_pc         <= pc;
        alu_result     <= alu_out;
        store_data     <= op2;          // forwarded rs2
        jump_target    <= target;
        csr_addr       <= inst[31:20];
        csr_write_data <= csr_new;
    end

    // no csr op redirects so memory never sees both
    a_csr_not_jump: assert property (@(posedge clk) disable iff (reset)
        !(csr_write_enable && jump_taken));

endmodule

`default_nettype wire

//--- verif/execute_ref.svh
`ifndef EXECUTE_REF_SVH
`define EXECUTE_REF_SVH

// one cycle of execute inputs, field names follow the DUT ports
typedef struct packed {
    logic               in_valid;
    isa_pkg::op_t       op;
    isa_pkg::inst_t     inst;
    isa_pkg::word_t     pc;
    isa_pkg::reg_addr_t rs1_addr;
    isa_pkg::reg_addr_t rs2_addr;
    isa_pkg::word_t     rs1_value;
    isa_pkg::word_t     rs2_value;
    isa_pkg::word_t     immed;
    isa_pkg::word_t     csr_value;
    isa_pkg::word_t     mtvec;
    isa_pkg::word_t     mepc;
    logic               fwd1_write_enable;
    isa_pkg::reg_addr_t fwd1_dest;
    isa_pkg::word_t     fwd1_data;
    logic               fwd2_write_enable;
    isa_pkg::reg_addr_t fwd2_dest;
    isa_pkg::word_t     fwd2_data;
} stim_t;

typedef struct packed {
    logic               valid;
    logic               taken;
    logic               csr_we;
    logic               ecall;
    logic               mret;
    logic               fwd_we;
    logic               has_result;   // alu_result is meaningful
    isa_pkg::op_t       op;
    isa_pkg::word_t     pc;
    isa_pkg::word_t     result;
    isa_pkg::word_t     store_data;
    isa_pkg::word_t     target;
    isa_pkg::word_t     csr_data;
    csr_pkg::csr_addr_t csr_addr;
    isa_pkg::reg_addr_t fwd_dest;
} expect_t;

function automatic isa_pkg::word_t bypass(input stim_t s, input isa_pkg::reg_addr_t src,
                                          input isa_pkg::word_t value);
    if (s.fwd1_write_enable && s.fwd1_dest != 5'd0 && s.fwd1_dest == src)
        return s.fwd1_data;
    if (s.fwd2_write_enable && s.fwd2_dest != 5'd0 && s.fwd2_dest == src)
        return s.fwd2_data;
    return value;
endfunction

function automatic isa_pkg::word_t sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

function automatic expect_t expected(input stim_t s);
    isa_pkg::word_t   a;
    isa_pkg::word_t   b;
    isa_pkg::word_t   src;
    csr_pkg::csr_op_t kind;
    logic             taken;
    logic             wr;
    expect_t          e;
    a = bypass(s, s.rs1_addr, s.rs1_value);
    b = bypass(s, s.rs2_addr, s.rs2_value);
    e = '0;
    taken = 1'b0;
    kind = csr_pkg::CSR_NONE;
    e.target = s.pc + s.immed;
    case (s.op)
        isa_pkg::ADD:   e.result = a + b;
        isa_pkg::SUB:   e.result = a - b;
        isa_pkg::AND:   e.result = a & b;
        isa_pkg::OR:    e.result = a | b;
        isa_pkg::XOR:   e.result = a ^ b;
        isa_pkg::SLL:   e.result = a << b[5:0];
        isa_pkg::SRL:   e.result = a >> b[5:0];
        isa_pkg::SRA:   e.result = $signed(a) >>> b[5:0];
        isa_pkg::SLT:   e.result = {63'b0, $signed(a) < $signed(b)};
        isa_pkg::SLTU:  e.result = {63'b0, a < b};
        isa_pkg::ADDI:  e.result = a + s.immed;
        isa_pkg::ANDI:  e.result = a & s.immed;
        isa_pkg::ORI:   e.result = a | s.immed;
        isa_pkg::XORI:  e.result = a ^ s.immed;
        isa_pkg::SLLI:  e.result = a << s.immed[5:0];
        isa_pkg::SRLI:  e.result = a >> s.immed[5:0];
        isa_pkg::SRAI:  e.result = $signed(a) >>> s.immed[5:0];
        isa_pkg::SLTI:  e.result = {63'b0, $signed(a) < $signed(s.immed)};
        isa_pkg::SLTIU: e.result = {63'b0, a < s.immed};
        isa_pkg::ADDW:  e.result = sext32(a[31:0] + b[31:0]);
        isa_pkg::SUBW:  e.result = sext32(a[31:0] - b[31:0]);
        isa_pkg::ADDIW: e.result = sext32(a[31:0] + s.immed[31:0]);
        isa_pkg::LUI:   e.result = s.immed;
        isa_pkg::AUIPC: e.result = s.pc + s.immed;
        isa_pkg::JAL: begin
            e.result = s.pc + 64'd4;
            taken = 1'b1;
        end
        isa_pkg::JALR: begin
            e.result = s.pc + 64'd4;
            taken = 1'b1;
            e.target = (a + s.immed) & ~64'h1;
        end
        isa_pkg::LD, isa_pkg::SD: e.result = a + s.immed;
        isa_pkg::BEQ:   taken = (a == b);
        isa_pkg::BNE:   taken = (a != b);
        isa_pkg::BLT:   taken = ($signed(a) < $signed(b));
        isa_pkg::BGE:   taken = ($signed(a) >= $signed(b));
        isa_pkg::BLTU:  taken = (a < b);
        isa_pkg::BGEU:  taken = (a >= b);
        isa_pkg::CSRRW, isa_pkg::CSRRWI: kind = csr_pkg::CSR_WRITE;
        isa_pkg::CSRRS, isa_pkg::CSRRSI: kind = csr_pkg::CSR_SET;
        isa_pkg::CSRRC, isa_pkg::CSRRCI: kind = csr_pkg::CSR_CLEAR;
        isa_pkg::ECALL: begin
            taken = 1'b1;
            e.target = s.mtvec;
        end
        isa_pkg::MRET: begin
            taken = 1'b1;
            e.target = s.mepc;
        end
        default: ;
    endcase
    // zimm forms take the rs1 field itself
    src = (s.op inside {isa_pkg::CSRRWI, isa_pkg::CSRRSI, isa_pkg::CSRRCI}) ?
          {59'b0, s.rs1_addr} : a;
    if (kind != csr_pkg::CSR_NONE)
        e.result = s.csr_value;
    case (kind)
        csr_pkg::CSR_WRITE: e.csr_data = src;
        csr_pkg::CSR_SET:   e.csr_data = s.csr_value | src;
        csr_pkg::CSR_CLEAR: e.csr_data = s.csr_value & ~src;
        default:            e.csr_data = s.csr_value;
    endcase
    wr = s.op inside {isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR,
                      isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA, isa_pkg::SLT, isa_pkg::SLTU,
                      isa_pkg::ADDI, isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::SLLI,
                      isa_pkg::SRLI, isa_pkg::SRAI, isa_pkg::SLTI, isa_pkg::SLTIU,
                      isa_pkg::ADDW, isa_pkg::SUBW, isa_pkg::ADDIW, isa_pkg::LUI,
                      isa_pkg::AUIPC, isa_pkg::JAL, isa_pkg::JALR, isa_pkg::LD,
                      isa_pkg::CSRRW, isa_pkg::CSRRS, isa_pkg::CSRRC,
                      isa_pkg::CSRRWI, isa_pkg::CSRRSI, isa_pkg::CSRRCI};
    e.valid      = s.in_valid;
    e.taken      = s.in_valid && taken;
    e.csr_we     = s.in_valid && (kind != csr_pkg::CSR_NONE);
    e.ecall      = s.in_valid && (s.op == isa_pkg::ECALL);
    e.mret       = s.in_valid && (s.op == isa_pkg::MRET);
    e.fwd_we     = s.in_valid && wr;
    e.has_result = wr || (s.op == isa_pkg::SD);
    e.op         = s.op;
    e.pc         = s.pc;
    e.store_data = b;
    e.csr_addr   = s.inst[31:20];
    e.fwd_dest   = s.inst[11:7];
    return e;
endfunction

`endif

//--- verif/execute_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execute_tb;

    `include "execute_ref.svh"

    localparam int RESET_CYCLES = 4;
    localparam int MAX_CYCLES   = 2200;   // ~2000 vectors plus reset and drain and some slack

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    stim_t              stim = '0;
    int                 cycles = 0;
    logic               pending = 1'b0;
    expect_t            want;
    expect_t            now_exp;

    logic               fwd_write_enable, out_valid, jump_taken, csr_write_enable, ecall, mret;
    isa_pkg::reg_addr_t fwd_dest;
    isa_pkg::op_t       out_op;
    csr_pkg::csr_addr_t csr_addr;
    isa_pkg::word_t     fwd_data, out_pc, alu_result, store_data, jump_target, csr_write_data;

    isa_pkg::op_t alu_ops [24] = '{isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::OR,
        isa_pkg::XOR, isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA, isa_pkg::SLT, isa_pkg::SLTU,
        isa_pkg::ADDI, isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::SLLI,
        isa_pkg::SRLI, isa_pkg::SRAI, isa_pkg::SLTI, isa_pkg::SLTIU, isa_pkg::ADDW,
        isa_pkg::SUBW, isa_pkg::ADDIW, isa_pkg::LUI, isa_pkg::AUIPC};
    isa_pkg::op_t jump_ops [8] = '{isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT, isa_pkg::BGE,
        isa_pkg::BLTU, isa_pkg::BGEU, isa_pkg::JAL, isa_pkg::JALR};
    isa_pkg::op_t csr_ops [6] = '{isa_pkg::CSRRW, isa_pkg::CSRRS, isa_pkg::CSRRC,
        isa_pkg::CSRRWI, isa_pkg::CSRRSI, isa_pkg::CSRRCI};
    isa_pkg::word_t edges [4] = '{64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff,
        64'hffff_ffff_ffff_ffff, 64'h0};   // signed compare corners

    execute i_execute (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (stim.in_valid),
        .op                (stim.op),
        .inst              (stim.inst),
        .pc                (stim.pc),
        .rs1_addr          (stim.rs1_addr),
        .rs2_addr          (stim.rs2_addr),
        .rs1_value         (stim.rs1_value),
        .rs2_value         (stim.rs2_value),
        .immed             (stim.immed),
        .csr_value         (stim.csr_value),
        .mtvec             (stim.mtvec),
        .mepc              (stim.mepc),
        .fwd1_write_enable (stim.fwd1_write_enable),
        .fwd1_dest         (stim.fwd1_dest),
        .fwd1_data         (stim.fwd1_data),
        .fwd2_write_enable (stim.fwd2_write_enable),
        .fwd2_dest         (stim.fwd2_dest),
        .fwd2_data         (stim.fwd2_data),
        .fwd_write_enable  (fwd_write_enable),
        .fwd_dest          (fwd_dest),
        .fwd_data          (fwd_data),
        .out_valid         (out_valid),
        .out_op            (out_op),
        .out_pc            (out_pc),
        .alu_result        (alu_result),
        .store_data        (store_data),
        .jump_taken        (jump_taken),
        .jump_target       (jump_target),
        .csr_write_enable  (csr_write_enable),
        .csr_addr          (csr_addr),
        .csr_write_data    (csr_write_data),
        .ecall             (ecall),
        .mret              (mret)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("TEST FAILED");
            $fatal(1, "timeout: simulation did not finish");
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive(input stim_t v);
        @(posedge clk);
        #1;
        stim = v;
    endtask

    function automatic isa_pkg::word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic stim_t random_vector(input isa_pkg::op_t op, input logic fwd_on);
        stim_t       s;
        logic [31:0] r;
        r = $urandom;
        s.in_valid          = ($urandom_range(7) != 0);   // one in eight is a bubble
        s.op                = op;
        s.inst              = $urandom;
        s.pc                = rand_word() & ~64'h3;
        s.rs1_addr          = 5'($urandom);
        s.rs2_addr          = 5'($urandom);
        s.rs1_value         = rand_word();
        s.rs2_value         = rand_word();
        if (op inside {isa_pkg::LUI, isa_pkg::AUIPC})
            s.immed = {{32{r[31]}}, r[31:12], 12'h000};
        else if (op inside {isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT, isa_pkg::BGE,
                            isa_pkg::BLTU, isa_pkg::BGEU, isa_pkg::JAL})
            s.immed = {{52{r[11]}}, r[11:1], 1'b0};   // branch offsets are even
        else
            s.immed = {{52{r[11]}}, r[11:0]};
        s.csr_value         = rand_word();
        s.mtvec             = rand_word() & ~64'h3;
        s.mepc              = rand_word() & ~64'h1;
        s.fwd1_write_enable = fwd_on && ($urandom_range(1) != 0);
        s.fwd1_dest         = 5'($urandom);
        s.fwd1_data         = rand_word();
        s.fwd2_write_enable = fwd_on && ($urandom_range(1) != 0);
        s.fwd2_dest         = 5'($urandom);
        s.fwd2_data         = rand_word();
        return s;
    endfunction

    // registered outputs lag the compare point by one clock
    always @(negedge clk) begin
        if (pending) begin
            check_value("out_valid", 64'(want.valid), 64'(out_valid));
            check_value("jump_taken", 64'(want.taken), 64'(jump_taken));
            check_value("csr_write_enable", 64'(want.csr_we), 64'(csr_write_enable));
            check_value("ecall", 64'(want.ecall), 64'(ecall));
            check_value("mret", 64'(want.mret), 64'(mret));
            if (want.valid) begin
                check_value("out_op", 64'(want.op), 64'(out_op));
                check_value("out_pc", want.pc, out_pc);
                check_value("store_data", want.store_data, store_data);
                if (want.has_result)
                    check_value("alu_result", want.result, alu_result);
                if (want.taken)
                    check_value("jump_target", want.target, jump_target);
                if (want.csr_we) begin
                    check_value("csr_addr", 64'(want.csr_addr), 64'(csr_addr));
                    check_value("csr_write_data", want.csr_data, csr_write_data);
                end
            end
        end
        if (reset) begin
            want = '0;
        end else begin
            now_exp = expected(stim);
            check_value("fwd_write_enable", 64'(now_exp.fwd_we), 64'(fwd_write_enable));
            if (now_exp.fwd_we) begin
                check_value("fwd_dest", 64'(now_exp.fwd_dest), 64'(fwd_dest));
                check_value("fwd_data", now_exp.result, fwd_data);
            end
            want = now_exp;
        end
        pending = 1'b1;
    end

    initial begin
        stim_t v;
        void'($urandom(32'hbd07));
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        repeat (500) begin
            drive(random_vector(alu_ops[$urandom_range(23)], 1'b0));
        end

        // narrow register range so the two ports and x0 collide often
        repeat (400) begin
            v = random_vector(alu_ops[$urandom_range(23)], 1'b1);
            if ($urandom_range(4) == 0)
                v.op = ($urandom_range(1) != 0) ? isa_pkg::LD : isa_pkg::SD;
            v.rs1_addr  = 5'($urandom_range(3));
            v.rs2_addr  = 5'($urandom_range(3));
            v.fwd1_dest = 5'($urandom_range(3));
            v.fwd2_dest = 5'($urandom_range(3));
            drive(v);
        end

        repeat (500) begin
            v = random_vector(jump_ops[$urandom_range(7)], 1'b0);
            case ($urandom_range(2))
                1: v.rs2_value = v.rs1_value;
                2: begin
                    v.rs1_value = edges[$urandom_range(3)];
                    v.rs2_value = edges[$urandom_range(3)];
                end
                default: ;
            endcase
            drive(v);
        end

        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 16; j++) begin
                v = random_vector(jump_ops[i], 1'b0);
                v.in_valid  = 1'b1;
                v.rs1_value = edges[j / 4];
                v.rs2_value = edges[j % 4];
                drive(v);
            end
        end

        repeat (400) begin
            drive(random_vector(csr_ops[$urandom_range(5)], 1'b1));
        end

        repeat (100) begin
            v = random_vector(($urandom_range(1) != 0) ? isa_pkg::ECALL : isa_pkg::MRET, 1'b0);
            drive(v);
        end

        drive('0);
        drive('0);
        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv64_execute.f
+incdir+verif
logic/isa_pkg.sv
logic/csr_pkg.sv
logic/operand_forward.sv
logic/alu.sv
logic/branch_unit.sv
logic/execute.sv
verif/execute_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= execute_tb
FLAGS     ?= --binary --timing --assert -j 0
FILELIST  ?= rv64_execute.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $$fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
